//--- verilog/calc_pkg.sv
package calc_pkg;

    localparam int num_width     = 4;               // operand magnitude
    localparam int mag_width     = 8;               // 15 * 15 fits
    localparam int bcd_digits    = 3;
    localparam int bcd_width     = 4 * bcd_digits;
    localparam int scan_div_bits = 10;              // refresh counter width

    typedef enum logic [1:0] {
        op_add  = 2'b00,
        op_sub  = 2'b01,
        op_mul  = 2'b10,
        op_pass = 2'b11
    } calc_op_e;

    typedef struct packed {
        calc_op_e             op;
        logic                 a_sign;               // 1 = negative
        logic [num_width-1:0] a;
        logic                 b_sign;
        logic [num_width-1:0] b;
    } calc_req_t;

    typedef struct packed {
        logic                       sign;
        logic [bcd_digits-1:0][3:0] bcd;            // [2] hundreds .. [0] ones
    } calc_res_t;

    typedef enum logic [1:0] {
        st_idle,
        st_start,
        st_convert,
        st_ack
    } ctrl_state_e;

endpackage

//--- verilog/sign_mag_alu.sv
module sign_mag_alu (
    input  calc_pkg::calc_op_e             op,
    input  logic [calc_pkg::num_width-1:0] a,
    input  logic [calc_pkg::num_width-1:0] b,
    input  logic                           a_sign,
    input  logic                           b_sign,
    output logic                           res_sign,
    output logic [calc_pkg::mag_width-1:0] res_mag
);

    logic                           b_sign_eff;
    logic                           raw_sign;
    logic [calc_pkg::mag_width-1:0] a_ext;
    logic [calc_pkg::mag_width-1:0] b_ext;

    assign a_ext = calc_pkg::mag_width'(a);
    assign b_ext = calc_pkg::mag_width'(b);

    // subtract is add with b negated
    assign b_sign_eff = (op == calc_pkg::op_sub) ? ~b_sign : b_sign;

    always_comb
    begin
        raw_sign = 1'b0;
        res_mag  = '0;
        case (op)
            calc_pkg::op_add, calc_pkg::op_sub:
            begin
                if (a_sign == b_sign_eff)
                begin
                    res_mag  = a_ext + b_ext;
                    raw_sign = a_sign;
                end
                else if (a >= b)
                begin
                    res_mag  = a_ext - b_ext;       // equal magnitudes land here as zero
                    raw_sign = a_sign;
                end
                else
                begin
                    res_mag  = b_ext - a_ext;
                    raw_sign = b_sign_eff;
                end
            end
            calc_pkg::op_mul:
            begin
                res_mag  = a_ext * b_ext;
                raw_sign = a_sign ^ b_sign;
            end
            calc_pkg::op_pass:
            begin
                res_mag  = a_ext;
                raw_sign = a_sign;
            end
            default:
            begin
                res_mag  = '0;
                raw_sign = 1'b0;
            end
        endcase
    end

    // no negative zero
    assign res_sign = raw_sign & (res_mag != '0);

endmodule

//--- verilog/bcd_converter.sv
module bcd_converter (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           start,
    input  logic [calc_pkg::mag_width-1:0] bin,
    output logic                           done,
    output logic [calc_pkg::bcd_width-1:0] bcd
);

    logic [calc_pkg::bcd_width+calc_pkg::mag_width-1:0] work;   // {bcd, remaining bits}
    logic [$clog2(calc_pkg::mag_width)-1:0]            bit_cnt;
    logic                                              busy;

    // one double-dabble step: add 3 to digits >= 5, then shift left
    function automatic logic [calc_pkg::bcd_width+calc_pkg::mag_width-1:0] dabble_step(
        input logic [calc_pkg::bcd_width+calc_pkg::mag_width-1:0] w
    );
        logic [calc_pkg::bcd_width+calc_pkg::mag_width-1:0] t;
        t = w;
        for (int i = 0; i < calc_pkg::bcd_digits; i++)
        begin
            if (t[calc_pkg::mag_width+4*i +: 4] >= 4'd5)
                t[calc_pkg::mag_width+4*i +: 4] = t[calc_pkg::mag_width+4*i +: 4] + 4'd3;
        end
        return t << 1;
    endfunction

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            busy    <= 1'b0;
            done    <= 1'b0;
            bit_cnt <= '0;
        end
        else
        begin
            done <= 1'b0;
            if (start)                                      // also restarts when busy
            begin
                busy    <= 1'b1;
                bit_cnt <= 1;                               // first step taken on load
            end
            else if (busy)
            begin
                bit_cnt <= bit_cnt + 1'b1;
                if (bit_cnt == calc_pkg::mag_width - 1)
                begin
                    busy <= 1'b0;
                    done <= 1'b1;                           // eighth step
                end
            end
        end
    end

    // datapath, no reset
    always_ff @(posedge clk)
    begin
        if (start)
            work <= dabble_step({{calc_pkg::bcd_width{1'b0}}, bin});
        else if (busy)
            work <= dabble_step(work);
    end

    assign bcd = work[calc_pkg::bcd_width+calc_pkg::mag_width-1:calc_pkg::mag_width];

endmodule

//--- verilog/calc_control.sv
module calc_control (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           req,
    input  calc_pkg::calc_req_t            operands,
    output logic                           ack,
    output calc_pkg::calc_req_t            alu_in,
    input  logic                           alu_sign,
    output logic                           start,
    input  logic                           done,
    input  logic [calc_pkg::bcd_width-1:0] bcd,
    output calc_pkg::calc_res_t            result
);

    calc_pkg::ctrl_state_e state;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state  <= calc_pkg::st_idle;
            result <= '0;                           // positive zero
        end
        else
        begin
            case (state)
                calc_pkg::st_idle:
                begin
                    if (req)
                        state <= calc_pkg::st_start;
                end
                calc_pkg::st_start:
                begin
                    state <= calc_pkg::st_convert;
                end
                calc_pkg::st_convert:
                begin
                    if (done)
                    begin
                        result.sign <= alu_sign;
                        result.bcd  <= bcd;
                        state       <= calc_pkg::st_ack;
                    end
                end
                calc_pkg::st_ack:
                begin
                    if (!req)
                        state <= calc_pkg::st_idle;     // four-phase release
                end
                default:
                begin
                    state <= calc_pkg::st_idle;
                end
            endcase
        end
    end

    // operand capture, held through the conversion
    always_ff @(posedge clk)
    begin
        if (state == calc_pkg::st_idle && req)
            alu_in <= operands;
    end

    assign start = (state == calc_pkg::st_start);
    assign ack   = (state == calc_pkg::st_ack);

endmodule

//--- verilog/display_scan.sv
module display_scan (
    input  logic                clk,
    input  logic                reset,
    input  calc_pkg::calc_res_t result,
    output logic [6:0]          seg_n,          // {g,f,e,d,c,b,a}
    output logic [3:0]          an_n            // [3] is the sign digit
);

    logic [calc_pkg::scan_div_bits-1:0] refresh_cnt;
    logic [1:0]                         digit_sel;
    logic                               scan_on;
    logic [3:0]                         digit_val;
    logic                               digit_blank;

    function automatic logic [6:0] seg_decode(input logic [3:0] d);
        case (d)
            4'd0:    return 7'b1000000;
            4'd1:    return 7'b1111001;
            4'd2:    return 7'b0100100;
            4'd3:    return 7'b0110000;
            4'd4:    return 7'b0011001;
            4'd5:    return 7'b0010010;
            4'd6:    return 7'b0000010;
            4'd7:    return 7'b1111000;
            4'd8:    return 7'b0000000;
            4'd9:    return 7'b0010000;
            default: return 7'b1111111;
        endcase
    endfunction

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            refresh_cnt <= '0;
            digit_sel   <= 2'd3;                // first step lands on the sign digit
            scan_on     <= 1'b0;
        end
        else
        begin
            refresh_cnt <= refresh_cnt + 1'b1;
            if (&refresh_cnt)
            begin
                digit_sel <= digit_sel + 2'd1;
                scan_on   <= 1'b1;
            end
        end
    end

    // leading zero blanking, ones always shown
    always_comb
    begin
        digit_val   = 4'd0;
        digit_blank = 1'b1;
        case (digit_sel)
            2'd1:
            begin
                digit_val   = result.bcd[2];
                digit_blank = (result.bcd[2] == 4'd0);
            end
            2'd2:
            begin
                digit_val   = result.bcd[1];
                digit_blank = (result.bcd[2] == 4'd0) && (result.bcd[1] == 4'd0);
            end
            2'd3:
            begin
                digit_val   = result.bcd[0];
                digit_blank = 1'b0;
            end
            default:
            begin
                digit_val   = 4'd0;
                digit_blank = 1'b1;
            end
        endcase
    end

    always_comb
    begin
        if (digit_sel == 2'd0)
            seg_n = result.sign ? 7'b0111111 : 7'b1111111;    // minus is segment g
        else if (digit_blank)
            seg_n = 7'b1111111;
        else
            seg_n = seg_decode(digit_val);
    end

    assign an_n = scan_on ? ~(4'b1000 >> digit_sel) : 4'b1111;

endmodule

//--- verilog/calculator_top.sv
module calculator_top (
    input  logic                clk,
    input  logic                reset,
    input  logic                req,
    input  calc_pkg::calc_req_t operands,
    output logic                ack,
    output calc_pkg::calc_res_t result,
    output logic [6:0]          seg_n,
    output logic [3:0]          an_n
);

    calc_pkg::calc_req_t            alu_in;
    logic                           alu_sign;
    logic [calc_pkg::mag_width-1:0] alu_mag;
    logic                           start;
    logic                           done;
    logic [calc_pkg::bcd_width-1:0] bcd;

    calc_control u_control (
        .clk      (clk),
        .reset    (reset),
        .req      (req),
        .operands (operands),
        .ack      (ack),
        .alu_in   (alu_in),
        .alu_sign (alu_sign),
        .start    (start),
        .done     (done),
        .bcd      (bcd),
        .result   (result)
    );

    sign_mag_alu u_alu (
        .op       (alu_in.op),
        .a        (alu_in.a),
        .b        (alu_in.b),
        .a_sign   (alu_in.a_sign),
        .b_sign   (alu_in.b_sign),
        .res_sign (alu_sign),
        .res_mag  (alu_mag)
    );

    bcd_converter u_bcd (
        .clk   (clk),
        .reset (reset),
        .start (start),
        .bin   (alu_mag),
        .done  (done),
        .bcd   (bcd)
    );

    display_scan u_display (
        .clk    (clk),
        .reset  (reset),
        .result (result),
        .seg_n  (seg_n),
        .an_n   (an_n)
    );

endmodule

//--- verification/calculator_asserts.sv
module calculator_asserts (
    input  logic                clk,
    input  logic                reset,
    input  logic                req,
    input  logic                ack,
    input  calc_pkg::calc_res_t result,
    input  logic [3:0]          an_n
);

    assert property (@(posedge clk) disable iff (reset) $rose(ack) |-> req)
        else $error("ack rose while req was low");

    // result only changes as ack rises
    assert property (@(posedge clk) disable iff (reset) !$rose(ack) |-> $stable(result))
        else $error("result changed outside a rising ack");

    assert property (@(posedge clk) disable iff (reset)
        result.bcd[2] <= 4'd9 && result.bcd[1] <= 4'd9 && result.bcd[0] <= 4'd9)
        else $error("result holds a BCD digit above 9");

    assert property (@(posedge clk) disable iff (reset) $countones(~an_n) <= 1)
        else $error("more than one display digit enabled");

endmodule

bind calculator_top calculator_asserts u_asserts (
    .clk    (clk),
    .reset  (reset),
    .req    (req),
    .ack    (ack),
    .result (result),
    .an_n   (an_n)
);

//--- verification/calculator_tb.sv
module calculator_tb;

    typedef struct packed {
        calc_pkg::calc_req_t req;
        logic                exp_sign;
        logic [7:0]          exp_mag;
    } vec_t;

    localparam int n_table     = 16;
    localparam int n_random    = 200;
    localparam int req_cycles  = 16;                // worst case per request, incl. hold
    localparam int scan_cycles = 4 * (2 ** calc_pkg::scan_div_bits);
    localparam int cycle_limit = (n_table + n_random) * req_cycles + scan_cycles + 100;

    localparam logic [6:0] seg_minus = 7'h3f;       // segment g only
    localparam logic [6:0] seg_digit [10] = '{7'h40, 7'h79, 7'h24, 7'h30, 7'h19,
                                              7'h12, 7'h02, 7'h78, 7'h00, 7'h10};

    // op, a_sign, a, b_sign, b, expected sign, expected magnitude
    localparam vec_t vectors [n_table] = '{
        {calc_pkg::op_add,  1'b0, 4'd3,  1'b0, 4'd4,  1'b0, 8'd7},
        {calc_pkg::op_add,  1'b1, 4'd3,  1'b1, 4'd4,  1'b1, 8'd7},
        {calc_pkg::op_add,  1'b0, 4'd5,  1'b1, 4'd5,  1'b0, 8'd0},
        {calc_pkg::op_add,  1'b1, 4'd9,  1'b0, 4'd2,  1'b1, 8'd7},
        {calc_pkg::op_add,  1'b0, 4'd2,  1'b1, 4'd9,  1'b1, 8'd7},
        {calc_pkg::op_add,  1'b0, 4'd15, 1'b0, 4'd15, 1'b0, 8'd30},
        {calc_pkg::op_sub,  1'b0, 4'd3,  1'b0, 4'd8,  1'b1, 8'd5},
        {calc_pkg::op_sub,  1'b1, 4'd3,  1'b1, 4'd3,  1'b0, 8'd0},
        {calc_pkg::op_sub,  1'b1, 4'd4,  1'b0, 4'd6,  1'b1, 8'd10},
        {calc_pkg::op_sub,  1'b0, 4'd9,  1'b1, 4'd6,  1'b0, 8'd15},
        {calc_pkg::op_mul,  1'b0, 4'd15, 1'b0, 4'd15, 1'b0, 8'd225},
        {calc_pkg::op_mul,  1'b1, 4'd7,  1'b0, 4'd8,  1'b1, 8'd56},
        {calc_pkg::op_mul,  1'b1, 4'd12, 1'b1, 4'd11, 1'b0, 8'd132},
        {calc_pkg::op_mul,  1'b1, 4'd9,  1'b0, 4'd0,  1'b0, 8'd0},
        {calc_pkg::op_pass, 1'b0, 4'd6,  1'b1, 4'd13, 1'b0, 8'd6},
        {calc_pkg::op_pass, 1'b1, 4'd9,  1'b0, 4'd15, 1'b1, 8'd9}   // negative, used for display
    };

    logic                clk;
    logic                reset;
    logic                req;
    calc_pkg::calc_req_t operands;
    logic                ack;
    calc_pkg::calc_res_t result;
    logic [6:0]          seg_n;
    logic [3:0]          an_n;
    int                  errors    = 0;
    int                  n_req     = 0;
    int                  cycle_cnt = 0;
    logic [31:0]         rng       = 32'hf63f;

    calculator_top UUT (
        .clk      (clk),
        .reset    (reset),
        .req      (req),
        .operands (operands),
        .ack      (ack),
        .result   (result),
        .seg_n    (seg_n),
        .an_n     (an_n)
    );

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk)
        cycle_cnt <= cycle_cnt + 1;

    initial
    begin
        wait (cycle_cnt >= cycle_limit);
        $display("timeout: run did not finish within %0d cycles", cycle_limit);
        $display("Test failures found");
        $finish;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic calc_pkg::calc_res_t to_res(input logic sign, input int mag);
        calc_pkg::calc_res_t r;
        r.sign   = sign;
        r.bcd[2] = 4'(mag / 100);
        r.bcd[1] = 4'((mag / 10) % 10);
        r.bcd[0] = 4'(mag % 10);
        return r;
    endfunction

    // signed integer view of the operands, zero comes out positive
    function automatic calc_pkg::calc_res_t model(input calc_pkg::calc_req_t r);
        int sa;
        int sb;
        int v;
        sa = r.a_sign ? -int'(r.a) : int'(r.a);
        sb = r.b_sign ? -int'(r.b) : int'(r.b);
        case (r.op)
            calc_pkg::op_add: v = sa + sb;
            calc_pkg::op_sub: v = sa - sb;
            calc_pkg::op_mul: v = sa * sb;
            default:          v = sa;
        endcase
        return to_res(v < 0, (v < 0) ? -v : v);
    endfunction

    task automatic mismatch(input string name, input logic [31:0] exp, input logic [31:0] got);
        errors++;
        $display("MISMATCH at %0t: %s expected %0h got %0h", $time, name, exp, got);
    endtask

    task automatic run_request(input calc_pkg::calc_req_t ops, input calc_pkg::calc_res_t exp);
        int                  lat;
        int                  hold;
        calc_pkg::calc_res_t held;
        @(posedge clk);
        operands <= ops;
        req      <= 1'b1;
        @(posedge clk);                             // edge 0
        lat = 0;
        @(negedge clk);
        while (ack !== 1'b1)
        begin
            @(negedge clk);
            lat++;
        end
        if (lat != 9)
            mismatch("ack latency", 9, lat);
        if (result !== exp)
            mismatch("result", exp, result);
        held = result;
        rng  = xorshift(rng);
        hold = rng % 3;
        repeat (hold)
        begin
            @(negedge clk);
            if (ack !== 1'b1)
                mismatch("ack", 1, ack);
            if (result !== held)
                mismatch("result", held, result);
        end
        @(posedge clk);
        req <= 1'b0;
        @(negedge clk);
        if (ack !== 1'b1)                           // low req not sampled yet
            mismatch("ack", 1, ack);
        @(negedge clk);
        if (ack !== 1'b0)
            mismatch("ack", 0, ack);
        n_req++;
    endtask

    task automatic check_display(input calc_pkg::calc_res_t exp);
        logic [3:0] prev;
        bit         seen_sign;
        bit         seen_ones;
        prev      = an_n;
        seen_sign = 1'b0;
        seen_ones = 1'b0;
        repeat (scan_cycles)
        begin
            @(negedge clk);
            if (an_n != prev)
            begin
                prev = an_n;
                if (an_n == 4'b0111)
                begin
                    seen_sign = 1'b1;
                    if (seg_n !== (exp.sign ? seg_minus : 7'h7f))
                        mismatch("seg_n", exp.sign ? seg_minus : 7'h7f, seg_n);
                end
                if (an_n == 4'b1110)
                begin
                    seen_ones = 1'b1;
                    if (seg_n !== seg_digit[exp.bcd[0]])
                        mismatch("seg_n", seg_digit[exp.bcd[0]], seg_n);
                end
            end
        end
        if (!(seen_sign && seen_ones))
        begin
            errors++;
            $display("display scan never enabled the sign and ones digits");
        end
    endtask

    initial
    begin
        calc_pkg::calc_req_t ops;
        reset    = 1'b1;
        req      = 1'b0;
        operands = '0;
        repeat (2) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        if (ack !== 1'b0)
            mismatch("ack", 0, ack);
        if (result !== '0)
            mismatch("result", 0, result);
        if (an_n !== 4'hf)
            mismatch("an_n", 4'hf, an_n);
        for (int i = 0; i < n_table; i++)
            run_request(vectors[i].req, to_res(vectors[i].exp_sign, vectors[i].exp_mag));
        // last table entry left a negative result
        check_display(to_res(vectors[n_table-1].exp_sign, vectors[n_table-1].exp_mag));
        for (int i = 0; i < n_random; i++)
        begin
            rng = xorshift(rng);
            ops = rng[11:0];
            run_request(ops, model(ops));
        end
        $display("%0d requests, %0d errors", n_req, errors);
        if (errors == 0)
            $display("All tests passed!");
        else
            $display("Test failures found");
        $finish;
    end

endmodule

//--- sim.f
verilog/calc_pkg.sv
verilog/sign_mag_alu.sv
verilog/bcd_converter.sv
verilog/calc_control.sv
verilog/display_scan.sv
verilog/calculator_top.sv
verification/calculator_asserts.sv
verification/calculator_tb.sv

//--- Bender.yml
package:
  name: calculator

sources:
  - verilog/calc_pkg.sv
  - verilog/sign_mag_alu.sv
  - verilog/bcd_converter.sv
  - verilog/calc_control.sv
  - verilog/display_scan.sv
  - verilog/calculator_top.sv
  - target: simulation
    files:
      - verification/calculator_asserts.sv
      - verification/calculator_tb.sv
